//--- src/serial_defines.svh
`ifndef SERIAL_DEFINES_SVH
`define SERIAL_DEFINES_SVH

// Width of the APB byte address seen by the serial port
`define SERIAL_ADDR_W 4

// System clocks between toggles of the internal serial clock
// A full bit therefore takes twice this many clocks
`define SERIAL_CLK_DIV 8

`endif

//--- src/serial_bus_pkg.sv
`default_nettype none

package serial_bus_pkg;

	// Register offsets decoded on the APB side
	// Any other offset is reported as an error
	typedef enum logic [3:0] {
		REG_SB = 4'h0,
		REG_SC = 4'h1
	} serial_reg_e;

	// Control register layout as software sees it
	// The clock select bit is 1 for the internal divider
	typedef struct packed {
		logic       start;
		logic [5:0] zero;
		logic       clk_sel;
	} sc_reg_t;

endpackage

`default_nettype wire

//--- src/serial_link_pkg.sv
`default_nettype none

package serial_link_pkg;

	// Where the serial clock comes from
	typedef enum logic {
		CLK_EXTERNAL = 1'b0,
		CLK_INTERNAL = 1'b1
	} clk_src_e;

	// Shift engine phase, named after the level of the serial clock
	typedef enum logic [1:0] {
		SHIFT_IDLE = 2'd0,
		SHIFT_LOW  = 2'd1,
		SHIFT_HIGH = 2'd2
	} shift_state_e;

endpackage

`default_nettype wire

//--- src/serial_ctrl_if.sv
`default_nettype none

interface serial_ctrl_if;

	// Register block to shift engine
	logic                      load;
	logic [7:0]                load_data;
	logic                      start;
	serial_link_pkg::clk_src_e clk_src;

	// Shift engine back to the register block
	logic [7:0]                shift_data;
	logic                      done;

	modport regs (
		output load, load_data, start, clk_src,
		input  shift_data, done
	);

	modport shifter (
		input  load, load_data, start, clk_src,
		output shift_data, done
	);

endinterface

`default_nettype wire

//--- src/serial_regs.sv
`default_nettype none

`include "serial_defines.svh"

module serial_regs (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      psel,
	input  logic                      penable,
	input  logic                      pwrite,
	input  logic [`SERIAL_ADDR_W-1:0] paddr,
	input  logic [7:0]                pwdata,
	output logic [7:0]                prdata,
	output logic                      pready,
	output logic                      pslverr,
	output logic                      int_serial,
	serial_ctrl_if.regs               ctrl
);

	serial_bus_pkg::sc_reg_t sc;

	logic access;
	logic sel_sb;
	logic sel_sc;
	logic sb_wr;
	logic sc_wr;

	// No wait states, so the access phase always completes
	assign access = psel && penable;
	assign pready = access;

	always_comb begin
		sel_sb = 1'b0;
		sel_sc = 1'b0;
		case (paddr)
			`SERIAL_ADDR_W'(serial_bus_pkg::REG_SB): sel_sb = 1'b1;
			`SERIAL_ADDR_W'(serial_bus_pkg::REG_SC): sel_sc = 1'b1;
			default: ;
		endcase
	end

	assign sb_wr = access && pwrite && sel_sb;
	assign sc_wr = access && pwrite && sel_sc;

	// SB is owned by the shift engine while a transfer runs
	assign pslverr = access && (!(sel_sb || sel_sc) || (sb_wr && sc.start));

	assign ctrl.load      = sb_wr && !sc.start;
	assign ctrl.load_data = pwdata;
	assign ctrl.start     = sc.start;
	assign ctrl.clk_src   = serial_link_pkg::clk_src_e'(sc.clk_sel);

	always_comb begin
		prdata = 8'h00;
		if (sel_sb)
			prdata = ctrl.shift_data;
		else if (sel_sc)
			prdata = sc;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sc         <= '0;
			int_serial <= 1'b0;
		end else begin
			int_serial <= ctrl.done;
			if (sc_wr)
				sc <= '{start: pwdata[7], zero: 6'd0, clk_sel: pwdata[0]};
			// Completion wins over a write landing on the same edge
			if (ctrl.done)
				sc.start <= 1'b0;
		end
	end

	// An error response belongs to an access phase that follows a setup phase
	a_err_in_access: assert property (
		@(posedge clk) disable iff (!rst_n)
		pslverr |-> $past(psel && !penable)
	);

	a_int_one_cycle: assert property (
		@(posedge clk) disable iff (!rst_n)
		int_serial |=> !int_serial
	);

endmodule

`default_nettype wire

//--- src/serial_shifter.sv
`default_nettype none

`include "serial_defines.svh"

module serial_shifter (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            sck_in,
	input  logic            sin_in,
	output logic            sck_out,
	output logic            sck_oe,
	output logic            ser_out,
	serial_ctrl_if.shifter  ctrl
);

	localparam int DIV_W = $clog2(`SERIAL_CLK_DIV);

	serial_link_pkg::shift_state_e state;

	logic [DIV_W-1:0] div_cnt;
	logic [3:0]       bit_cnt;
	logic [7:0]       sb;
	logic             hold;
	logic [2:0]       sck_sync;
	logic             internal;
	logic             active;
	logic             tick;
	logic             ext_rise;
	logic             ext_fall;
	logic             fall_ev;
	logic             rise_ev;
	logic             last_bit;

	assign internal = ctrl.clk_src == serial_link_pkg::CLK_INTERNAL;
	assign active   = state != serial_link_pkg::SHIFT_IDLE;
	assign tick     = internal && active && div_cnt == DIV_W'(`SERIAL_CLK_DIV - 1);

	// Bits 1:0 synchronize the pin, bit 2 keeps the previous level for edge detection
	always_ff @(posedge clk) begin
		if (!rst_n)
			sck_sync <= '0;
		else
			sck_sync <= {sck_sync[1:0], sck_in};
	end

	assign ext_rise = !internal && sck_sync[1] && !sck_sync[2];
	assign ext_fall = !internal && !sck_sync[1] && sck_sync[2];

	// Edges are only honoured in the phase that expects them
	assign fall_ev  = ctrl.start && state == serial_link_pkg::SHIFT_HIGH && (tick || ext_fall);
	assign rise_ev  = ctrl.start && state == serial_link_pkg::SHIFT_LOW && (tick || ext_rise);
	assign last_bit = bit_cnt == 4'd7;

	always_ff @(posedge clk) begin
		if (!rst_n)
			div_cnt <= '0;
		else if (!active || tick)
			div_cnt <= '0;
		else if (internal)
			div_cnt <= div_cnt + DIV_W'(1);
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state     <= serial_link_pkg::SHIFT_IDLE;
			bit_cnt   <= '0;
			ctrl.done <= 1'b0;
		end else begin
			ctrl.done <= 1'b0;
			case (state)
				serial_link_pkg::SHIFT_IDLE: begin
					bit_cnt <= '0;
					// Start is still set in the cycle done is high, so wait for it to clear
					if (ctrl.start && !ctrl.done)
						state <= serial_link_pkg::SHIFT_HIGH;
				end
				serial_link_pkg::SHIFT_HIGH: begin
					if (!ctrl.start)
						state <= serial_link_pkg::SHIFT_IDLE;
					else if (fall_ev)
						state <= serial_link_pkg::SHIFT_LOW;
				end
				serial_link_pkg::SHIFT_LOW: begin
					if (!ctrl.start) begin
						state <= serial_link_pkg::SHIFT_IDLE;
					end else if (rise_ev) begin
						bit_cnt <= bit_cnt + 4'd1;
						if (last_bit) begin
							state     <= serial_link_pkg::SHIFT_IDLE;
							ctrl.done <= 1'b1;
						end else begin
							state <= serial_link_pkg::SHIFT_HIGH;
						end
					end
				end
				default: state <= serial_link_pkg::SHIFT_IDLE;
			endcase
		end
	end

	// The first falling edge only presents bit 7, later ones shift in the held bit
	always_ff @(posedge clk) begin
		if (!rst_n)
			sb <= '0;
		else if (ctrl.load)
			sb <= ctrl.load_data;
		else if (fall_ev && bit_cnt != 4'd0)
			sb <= {sb[6:0], hold};
		else if (rise_ev && last_bit)
			sb <= {sb[6:0], sin_in};
	end

	always_ff @(posedge clk) begin
		if (rise_ev)
			hold <= sin_in;
	end

	assign ser_out         = sb[7];
	assign sck_oe          = internal;
	assign sck_out         = internal && state != serial_link_pkg::SHIFT_LOW;
	assign ctrl.shift_data = sb;

	a_bit_cnt_range: assert property (
		@(posedge clk) disable iff (!rst_n)
		bit_cnt <= 4'd8
	);

	a_load_when_idle: assert property (
		@(posedge clk) disable iff (!rst_n)
		ctrl.load |-> state == serial_link_pkg::SHIFT_IDLE
	);

endmodule

`default_nettype wire

//--- src/serial_top.sv
`default_nettype none

`include "serial_defines.svh"

module serial_top (
	input  logic                      clk,
	input  logic                      rst_n,

	// APB slave
	input  logic                      psel,
	input  logic                      penable,
	input  logic                      pwrite,
	input  logic [`SERIAL_ADDR_W-1:0] paddr,
	input  logic [7:0]                pwdata,
	output logic [7:0]                prdata,
	output logic                      pready,
	output logic                      pslverr,
	output logic                      int_serial,

	// Link pins
	input  logic                      sck_in,
	input  logic                      sin_in,
	output logic                      sck_out,
	output logic                      sck_oe,
	output logic                      ser_out
);

	serial_ctrl_if ctrl ();

	serial_regs u_regs (
		.clk        (clk),
		.rst_n      (rst_n),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr),
		.int_serial (int_serial),
		.ctrl       (ctrl)
	);

	serial_shifter u_shifter (
		.clk     (clk),
		.rst_n   (rst_n),
		.sck_in  (sck_in),
		.sin_in  (sin_in),
		.sck_out (sck_out),
		.sck_oe  (sck_oe),
		.ser_out (ser_out),
		.ctrl    (ctrl)
	);

endmodule

`default_nettype wire

//--- bench/serial_tb.sv
`default_nettype none

`include "serial_defines.svh"

module serial_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int EXT_HALF         = 6;
	localparam int RANDOM_TRANSFERS = 20;
	localparam int TRANSFERS        = RANDOM_TRANSFERS + 3;
	localparam int INT_LATENCY      = 16 * `SERIAL_CLK_DIV + 2;
	localparam int WAIT_LIMIT       = 16 * `SERIAL_CLK_DIV * 4;
	localparam int WATCHDOG_NS      = TRANSFERS * 16 * `SERIAL_CLK_DIV * 10 * 4 + 50000;

	localparam logic [`SERIAL_ADDR_W-1:0] ADDR_SB = `SERIAL_ADDR_W'(serial_bus_pkg::REG_SB);
	localparam logic [`SERIAL_ADDR_W-1:0] ADDR_SC = `SERIAL_ADDR_W'(serial_bus_pkg::REG_SC);

	logic                      clk;
	logic                      rst_n;
	logic                      psel;
	logic                      penable;
	logic                      pwrite;
	logic [`SERIAL_ADDR_W-1:0] paddr;
	logic [7:0]                pwdata;
	logic [7:0]                prdata;
	logic                      pready;
	logic                      pslverr;
	logic                      int_serial;
	logic                      sck_in;
	logic                      sin_in;
	logic                      sck_out;
	logic                      sck_oe;
	logic                      ser_out;

	logic [31:0] rng_state;
	int          errors;

	// Peer side of the link
	logic [7:0] peer_reg;
	logic [7:0] rx_byte;
	int         rx_count;
	int         ext_toggles;
	int         ext_div;
	logic       sck_now;
	logic       sck_prev;
	logic       last_low;

	// What software expects SB and the SC clock select to hold
	logic [7:0] model_sb;
	logic       model_src;

	serial_top uut (
		.clk        (clk),
		.rst_n      (rst_n),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr),
		.int_serial (int_serial),
		.sck_in     (sck_in),
		.sin_in     (sin_in),
		.sck_out    (sck_out),
		.sck_oe     (sck_oe),
		.ser_out    (ser_out)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the run is stuck", WATCHDOG_NS);
		$display("TEST FAIL");
		$fatal(1, "watchdog");
	end

	function logic [7:0] next_random();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state[31:24];
	endfunction

	task automatic report_mismatch(input string name, input int expected, input int actual);
		errors++;
		$display("error %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
		$display("TEST FAIL");
		$fatal(1, "value check failed");
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("failure: %s", what);
		$display("TEST FAIL");
		$fatal(1, "check failed");
	endtask

	task automatic check_value(input string name, input int expected, input int actual);
		assert (actual == expected) else report_mismatch(name, expected, actual);
	endtask

	// Clock generator for external mode, peer data and bit capture all live here
	// A bit is taken from the last low-phase sample of ser_out before sck rises
	always @(posedge clk) begin
		#1;
		if (ext_toggles > 0) begin
			ext_div++;
			if (ext_div == EXT_HALF) begin
				ext_div = 0;
				sck_in = !sck_in;
				ext_toggles--;
			end
		end
		sck_now = sck_oe ? sck_out : sck_in;
		if (sck_prev && !sck_now)
			sin_in = peer_reg[7];
		if (!sck_prev && sck_now) begin
			rx_byte = {rx_byte[6:0], last_low};
			rx_count++;
			peer_reg = {peer_reg[6:0], 1'b0};
		end
		if (!sck_now)
			last_low = ser_out;
		sck_prev = sck_now;
	end

	task automatic apb_write(input logic [`SERIAL_ADDR_W-1:0] addr, input logic [7:0] data,
			output logic err);
		@(posedge clk);
		#1;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(posedge clk);
		#1;
		penable = 1'b1;
		#4;
		assert (pready) else report_failure("pready low in a write access phase");
		err = pslverr;
		@(posedge clk);
		#1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_read(input logic [`SERIAL_ADDR_W-1:0] addr, output logic [7:0] data,
			output logic err);
		@(posedge clk);
		#1;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = addr;
		@(posedge clk);
		#1;
		penable = 1'b1;
		#4;
		assert (pready) else report_failure("pready low in a read access phase");
		data = prdata;
		err = pslverr;
		@(posedge clk);
		#1;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic check_regs(input string name);
		logic [7:0] rd;
		logic       err;
		apb_read(ADDR_SB, rd, err);
		check_value({name, " sb"}, int'(model_sb), int'(rd));
		check_value({name, " sb pslverr"}, 0, int'(err));
		apb_read(ADDR_SC, rd, err);
		check_value({name, " sc"}, int'({7'b0, model_src}), int'(rd));
		check_value({name, " sc pslverr"}, 0, int'(err));
	endtask

	task automatic idle_access(input logic [1:0] op);
		logic [7:0]                r;
		logic [7:0]                rd;
		logic [`SERIAL_ADDR_W-1:0] addr;
		logic                      err;
		r = next_random();
		case (op)
			2'd0: begin
				model_sb = r;
				apb_write(ADDR_SB, r, err);
				check_value("idle sb write pslverr", 0, int'(err));
				check_regs("idle sb readback");
			end
			2'd1: begin
				// Start stays clear, the other bits are random
				model_src = r[0];
				apb_write(ADDR_SC, r & 8'h7f, err);
				check_value("idle sc write pslverr", 0, int'(err));
				check_regs("idle sc readback");
			end
			2'd2: begin
				addr = `SERIAL_ADDR_W'(2 + int'(r[7:2]) % 14);
				apb_read(addr, rd, err);
				check_value("unmapped read data", 0, int'(rd));
				check_value("unmapped read pslverr", 1, int'(err));
				apb_write(addr, r, err);
				check_value("unmapped write pslverr", 1, int'(err));
				check_regs("after unmapped write");
			end
			default: check_regs("idle read");
		endcase
	endtask

	task automatic run_transfer(input string name, input logic [7:0] tx, input logic [7:0] peer,
			input logic internal, input logic inject);
		logic [7:0] junk;
		logic       err;
		int         cycles;
		apb_write(ADDR_SB, tx, err);
		check_value({name, " sb write pslverr"}, 0, int'(err));
		peer_reg = peer;
		sin_in = peer[7];
		rx_count = 0;
		rx_byte = 8'h00;
		junk = next_random();
		apb_write(ADDR_SC, {1'b1, junk[6:1], internal}, err);
		check_value({name, " start pslverr"}, 0, int'(err));
		cycles = 0;
		if (!internal) begin
			ext_div = 0;
			ext_toggles = 16;
		end
		if (inject) begin
			apb_write(ADDR_SB, ~tx, err);
			check_value({name, " busy sb write pslverr"}, 1, int'(err));
			cycles = 3;
		end
		while (!int_serial) begin
			@(posedge clk);
			#1;
			cycles++;
			assert (sck_oe == internal) else report_failure("sck_oe does not follow the clock source");
			assert (cycles <= WAIT_LIMIT) else report_failure("timeout waiting for int_serial");
		end
		if (internal)
			check_value({name, " interrupt latency"}, INT_LATENCY, cycles);
		@(posedge clk);
		#1;
		assert (!int_serial) else report_failure("int_serial stayed high for two cycles");
		check_value({name, " bit count"}, 8, rx_count);
		check_value({name, " outgoing bits"}, int'(tx), int'(rx_byte));
		model_sb = peer;
		model_src = internal;
		check_regs({name, " result"});
	endtask

	initial begin
		logic [7:0] tx;
		logic [7:0] peer;
		logic [7:0] r;
		logic [7:0] op;
		rng_state = 32'd18996;
		errors = 0;
		rst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = 8'h00;
		sck_in = 1'b1;
		sin_in = 1'b0;
		peer_reg = 8'h00;
		rx_byte = 8'h00;
		rx_count = 0;
		ext_toggles = 0;
		ext_div = 0;
		sck_prev = 1'b1;
		last_low = 1'b0;
		model_sb = 8'h00;
		model_src = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;

		assert (!int_serial && !sck_out && !sck_oe && !ser_out)
			else report_failure("link outputs are not low after reset");
		check_regs("reset");

		for (int i = 0; i < 8; i++)
			idle_access(2'(i));

		tx = next_random();
		peer = next_random();
		run_transfer("internal transfer", tx, peer, 1'b1, 1'b0);
		tx = next_random();
		peer = next_random();
		run_transfer("external transfer", tx, peer, 1'b0, 1'b0);
		tx = next_random();
		peer = next_random();
		run_transfer("busy write", tx, peer, 1'b1, 1'b1);

		for (int i = 0; i < RANDOM_TRANSFERS; i++) begin
			r = next_random();
			repeat (int'(r[1:0])) begin
				op = next_random();
				idle_access(op[1:0]);
			end
			tx = next_random();
			peer = next_random();
			run_transfer("random transfer", tx, peer, r[7], 1'b0);
		end

		if (errors == 0) begin
			$display("TEST PASS");
			$finish;
		end else begin
			$display("TEST FAIL");
			$fatal(1, "checks failed");
		end
	end

endmodule

`default_nettype wire

//--- files.f
+incdir+src
src/serial_bus_pkg.sv
src/serial_link_pkg.sv
src/serial_ctrl_if.sv
src/serial_regs.sv
src/serial_shifter.sv
src/serial_top.sv
bench/serial_tb.sv

//--- Makefile
TOP = serial_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f files.f --top-module $(TOP) -o V$(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASS$$"

lint:
	verilator --lint-only --timing --timescale 1ns/100ps \
		-f files.f --top-module serial_top

clean:
	rm -rf obj_dir
